// ==== hdl/ising_pkg.sv ====
// sizes of the spin problem and the bus
// register map of the host port
// coupling row type, raw bus word or per-spin coefficients

package ising_pkg;

    localparam int NUM_SPIN   = 8;
    localparam int BIT_J      = 4;  // signed coupling
    localparam int BIT_H      = 4;  // signed bias
    localparam int SWEEP_BITS = 4;
    localparam int FIELD_BITS = 8;  // 7*8 + 8 worst case fits
    localparam int DATA_W     = 32;
    localparam int STRB_W     = DATA_W / 8;
    localparam int ROW_BITS   = $clog2(NUM_SPIN);

    //////////////////////////////////////////////////
    // register map, byte addresses
    //////////////////////////////////////////////////
    localparam logic [7:0] REG_CTRL        = 8'h00;
    localparam logic [7:0] REG_STATUS      = 8'h04;
    localparam logic [7:0] REG_SWEEPS      = 8'h08;
    localparam logic [7:0] REG_SPIN_INIT   = 8'h0C;
    localparam logic [7:0] REG_SPIN_RESULT = 8'h10;
    localparam logic [7:0] REG_HBIAS       = 8'h14;
    localparam logic [7:0] J_BASE          = 8'h20;
    localparam int         J_SPAN          = NUM_SPIN * STRB_W;  // one word per row

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef logic signed [BIT_J-1:0] j_coef_t;

    // one coupling row, element j is J_ij
    typedef union packed {
        logic [DATA_W-1:0]          raw;
        j_coef_t [NUM_SPIN-1:0]     coef;
    } j_row_u;

endpackage

// ==== hdl/coupling_mem.sv ====
`timescale 1ns/10ps
// coupling row storage, one row per spin
// host port writes and reads rows, engine port reads them

module coupling_mem import ising_pkg::*; (
    input  logic                clk_i,
    input  logic                host_we_i,
    input  logic                host_re_i,
    input  logic [ROW_BITS-1:0] host_addr_i,
    input  logic [DATA_W-1:0]   host_wdata_i,
    output logic [DATA_W-1:0]   host_rdata_o,
    input  logic                eng_re_i,
    input  logic [ROW_BITS-1:0] eng_addr_i,
    output j_row_u              eng_rdata_o
);
    j_row_u rows_q [NUM_SPIN];

    // host writes are already refused during a run
    always_ff @(posedge clk_i) begin
        if (host_we_i) begin
            rows_q[host_addr_i].raw <= host_wdata_i;
        end
    end

    // both read ports registered, 1 cycle latency
    always_ff @(posedge clk_i) begin
        if (host_re_i) begin
            host_rdata_o <= rows_q[host_addr_i].raw;
        end
        if (eng_re_i) begin
            eng_rdata_o <= rows_q[eng_addr_i];
        end
    end

endmodule

// ==== hdl/spin_engine.sv ====
`timescale 1ns/10ps
// sequential zero temperature spin update engine
// sweep control, row fetch and local field sum

module spin_engine import ising_pkg::*; (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      start_i,
    input  logic [SWEEP_BITS-1:0]     sweeps_i,
    input  logic [NUM_SPIN-1:0]       spin_init_i,
    input  logic [NUM_SPIN*BIT_H-1:0] hbias_i,
    output logic                      mem_re_o,
    output logic [ROW_BITS-1:0]       mem_addr_o,
    input  j_row_u                    mem_rdata_i,
    output logic                      busy_o,
    output logic                      done_o,
    output logic [NUM_SPIN-1:0]       spin_result_o
);
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,    // fetch row idx
        ST_UPDATE   // row valid, update spin idx
    } state_t;

    state_t                       state_q;
    logic [ROW_BITS-1:0]          idx_q;
    logic [SWEEP_BITS-1:0]        sweep_left_q;
    logic [NUM_SPIN-1:0]          spin_q;
    logic signed [FIELD_BITS-1:0] field;
    logic                         run_empty, last_spin;

    assign busy_o        = (state_q != ST_IDLE);
    assign run_empty     = (state_q == ST_READ) && (sweep_left_q == '0);
    assign last_spin     = (state_q == ST_UPDATE) && (idx_q == ROW_BITS'(NUM_SPIN - 1))
                         && (sweep_left_q == SWEEP_BITS'(1));
    assign done_o        = run_empty | last_spin;  // same edge busy falls
    assign mem_re_o      = (state_q == ST_READ) && (sweep_left_q != '0);
    assign mem_addr_o    = idx_q;
    assign spin_result_o = spin_q;

    //////////////////////////////////////////////////
    // local field h_i + sum J_ij * s_j
    //////////////////////////////////////////////////
    always_comb begin : local_field
        logic signed [FIELD_BITS-1:0] term;
        field = FIELD_BITS'($signed(hbias_i[idx_q*BIT_H +: BIT_H]));
        for (int j = 0; j < NUM_SPIN; j++) begin
            term = FIELD_BITS'(mem_rdata_i.coef[j]);  // widen before negating -8
            if (j != int'(idx_q)) begin
                // bit 1 is +1, bit 0 is -1
                field = spin_q[j] ? field + term : field - term;
            end
        end
    end

    //////////////////////////////////////////////////
    // sweep control
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q      <= ST_IDLE;
            idx_q        <= '0;
            sweep_left_q <= '0;
            spin_q       <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        spin_q       <= spin_init_i;
                        sweep_left_q <= sweeps_i;
                        idx_q        <= '0;
                        state_q      <= ST_READ;
                    end
                end
                ST_READ: begin
                    state_q <= run_empty ? ST_IDLE : ST_UPDATE;  // zero sweeps, one busy cycle
                end
                ST_UPDATE: begin
                    spin_q[idx_q] <= ~field[FIELD_BITS-1];  // field >= 0 gives +1
                    idx_q         <= idx_q + 1'b1;          // wraps to 0 after last spin
                    if (idx_q == ROW_BITS'(NUM_SPIN - 1)) begin
                        sweep_left_q <= sweep_left_q - 1'b1;
                    end
                    state_q <= last_spin ? ST_IDLE : ST_READ;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    a_read_busy: assert property (@(posedge clk_i) disable iff (reset_i)
        mem_re_o |-> busy_o)
        else $error("coupling read outside a run");

endmodule

// ==== hdl/ising_regs.sv ====
`timescale 1ns/10ps
// AXI4-Lite slave of the ising core
// configuration and status registers, start pulse, sticky done
// J row accesses forwarded to the coupling memory

module ising_regs import ising_pkg::*; #(
    parameter int ADDR_W = 8
) (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic [ADDR_W-1:0]         s_axi_awaddr_i,
    input  logic                      s_axi_awvalid_i,
    output logic                      s_axi_awready_o,
    input  logic [DATA_W-1:0]         s_axi_wdata_i,
    input  logic [STRB_W-1:0]         s_axi_wstrb_i,
    input  logic                      s_axi_wvalid_i,
    output logic                      s_axi_wready_o,
    output logic [1:0]                s_axi_bresp_o,
    output logic                      s_axi_bvalid_o,
    input  logic                      s_axi_bready_i,
    input  logic [ADDR_W-1:0]         s_axi_araddr_i,
    input  logic                      s_axi_arvalid_i,
    output logic                      s_axi_arready_o,
    output logic [DATA_W-1:0]         s_axi_rdata_o,
    output logic [1:0]                s_axi_rresp_o,
    output logic                      s_axi_rvalid_o,
    input  logic                      s_axi_rready_i,
    output logic                      start_o,
    output logic [SWEEP_BITS-1:0]     sweeps_o,
    output logic [NUM_SPIN-1:0]       spin_init_o,
    output logic [NUM_SPIN*BIT_H-1:0] hbias_o,
    output logic                      mem_we_o,
    output logic                      mem_re_o,
    output logic [ROW_BITS-1:0]       mem_addr_o,
    output logic [DATA_W-1:0]         mem_wdata_o,
    input  logic [DATA_W-1:0]         mem_rdata_i,
    input  logic                      busy_i,
    input  logic                      done_i,
    input  logic [NUM_SPIN-1:0]       spin_result_i
);
    logic [ADDR_W-1:0] aw_word, ar_word, rd_addr_q;
    logic              aw_go, ar_go, wr_fire, ar_fire;
    logic              wr_is_j, start_req, refuse;
    logic              rd_stage1_q, rd_stage2_q, done_q;
    logic [DATA_W-1:0] rd_word;

    function automatic logic is_j_addr(logic [ADDR_W-1:0] a);
        return (a >= ADDR_W'(J_BASE)) && (a < ADDR_W'(J_BASE + J_SPAN));
    endfunction

    //////////////////////////////////////////////////
    // write path
    //////////////////////////////////////////////////
    assign aw_word   = {s_axi_awaddr_i[ADDR_W-1:2], 2'b00};
    assign wr_fire   = s_axi_awready_o & s_axi_awvalid_i & s_axi_wvalid_i;
    assign wr_is_j   = is_j_addr(aw_word);
    assign start_req = (aw_word == ADDR_W'(REG_CTRL)) & s_axi_wstrb_i[0] & s_axi_wdata_i[0];
    assign refuse    = busy_i & (wr_is_j | start_req);  // engine owns rows during a run

    // aw and ar never granted in the same cycle, they share the memory address
    assign aw_go = s_axi_awvalid_i & s_axi_wvalid_i & ~s_axi_awready_o & ~s_axi_bvalid_o;
    assign ar_go = s_axi_arvalid_i & ~s_axi_arready_o & ~rd_stage1_q & ~rd_stage2_q
                 & ~s_axi_rvalid_o & ~aw_go;

    // rows are written as whole words
    assign mem_we_o    = wr_fire & wr_is_j & ~busy_i;
    assign mem_re_o    = ar_fire & is_j_addr(ar_word);
    assign mem_addr_o  = ar_fire ? ar_word[ROW_BITS+1:2] : aw_word[ROW_BITS+1:2];
    assign mem_wdata_o = s_axi_wdata_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            s_axi_awready_o <= 1'b0;
            s_axi_wready_o  <= 1'b0;
            s_axi_arready_o <= 1'b0;
            s_axi_bvalid_o  <= 1'b0;
            s_axi_bresp_o   <= RESP_OKAY;
            start_o         <= 1'b0;
        end else begin
            s_axi_awready_o <= aw_go;  // one cycle pulse
            s_axi_wready_o  <= aw_go;
            s_axi_arready_o <= ar_go;
            start_o         <= wr_fire & start_req & ~busy_i;
            if (wr_fire) begin
                s_axi_bvalid_o <= 1'b1;
                s_axi_bresp_o  <= refuse ? RESP_SLVERR : RESP_OKAY;
            end else if (s_axi_bready_i) begin
                s_axi_bvalid_o <= 1'b0;
            end
        end
    end

    // config registers with byte strobes
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sweeps_o    <= '0;
            spin_init_o <= '0;
            hbias_o     <= '0;
            done_q      <= 1'b0;
        end else begin
            if (wr_fire) begin
                case (aw_word)
                    ADDR_W'(REG_SWEEPS):
                        if (s_axi_wstrb_i[0]) sweeps_o <= s_axi_wdata_i[SWEEP_BITS-1:0];
                    ADDR_W'(REG_SPIN_INIT):
                        if (s_axi_wstrb_i[0]) spin_init_o <= s_axi_wdata_i[NUM_SPIN-1:0];
                    ADDR_W'(REG_HBIAS):
                        for (int b = 0; b < STRB_W; b++) begin
                            if (s_axi_wstrb_i[b]) hbias_o[8*b +: 8] <= s_axi_wdata_i[8*b +: 8];
                        end
                    default: ;
                endcase
            end
            if (start_o) begin
                done_q <= 1'b0;
            end else if (done_i) begin
                done_q <= 1'b1;  // sticky until next start
            end
        end
    end

    //////////////////////////////////////////////////
    // read path, fixed 2 cycle latency
    //////////////////////////////////////////////////
    assign ar_word       = {s_axi_araddr_i[ADDR_W-1:2], 2'b00};
    assign ar_fire       = s_axi_arready_o & s_axi_arvalid_i;
    assign s_axi_rresp_o = RESP_OKAY;

    always_comb begin
        rd_word = '0;
        if (is_j_addr(rd_addr_q)) begin
            rd_word = mem_rdata_i;  // row read issued on ar handshake
        end else begin
            case (rd_addr_q)
                ADDR_W'(REG_STATUS):      rd_word = DATA_W'({done_q, busy_i});
                ADDR_W'(REG_SWEEPS):      rd_word = DATA_W'(sweeps_o);
                ADDR_W'(REG_SPIN_INIT):   rd_word = DATA_W'(spin_init_o);
                ADDR_W'(REG_SPIN_RESULT): rd_word = DATA_W'(spin_result_i);
                ADDR_W'(REG_HBIAS):       rd_word = hbias_o;
                default:                  rd_word = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_stage1_q    <= 1'b0;
            rd_stage2_q    <= 1'b0;
            s_axi_rvalid_o <= 1'b0;
        end else begin
            rd_stage1_q <= ar_fire;
            rd_stage2_q <= rd_stage1_q;
            if (rd_stage2_q) begin
                s_axi_rvalid_o <= 1'b1;
            end else if (s_axi_rready_i) begin
                s_axi_rvalid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (ar_fire) rd_addr_q <= ar_word;
        if (rd_stage1_q) s_axi_rdata_o <= rd_word;  // held until next read is accepted
    end

    a_rdata_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        s_axi_rvalid_o && !s_axi_rready_i |=> s_axi_rvalid_o && $stable(s_axi_rdata_o))
        else $error("rdata changed or rvalid dropped before rready");

    a_no_start_busy: assert property (@(posedge clk_i) disable iff (reset_i)
        start_o |-> !busy_i)
        else $error("start issued while engine busy");

endmodule

// ==== hdl/ising_core_top.sv ====
`timescale 1ns/10ps
// top level of the ising annealing core
// register port, coupling memory and spin engine

module ising_core_top import ising_pkg::*; #(
    parameter int ADDR_W = 8
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic [ADDR_W-1:0] s_axi_awaddr_i,
    input  logic              s_axi_awvalid_i,
    output logic              s_axi_awready_o,
    input  logic [DATA_W-1:0] s_axi_wdata_i,
    input  logic [STRB_W-1:0] s_axi_wstrb_i,
    input  logic              s_axi_wvalid_i,
    output logic              s_axi_wready_o,
    output logic [1:0]        s_axi_bresp_o,
    output logic              s_axi_bvalid_o,
    input  logic              s_axi_bready_i,
    input  logic [ADDR_W-1:0] s_axi_araddr_i,
    input  logic              s_axi_arvalid_i,
    output logic              s_axi_arready_o,
    output logic [DATA_W-1:0] s_axi_rdata_o,
    output logic [1:0]        s_axi_rresp_o,
    output logic              s_axi_rvalid_o,
    input  logic              s_axi_rready_i
);
    logic                      start, busy, done;
    logic [SWEEP_BITS-1:0]     sweeps;
    logic [NUM_SPIN-1:0]       spin_init, spin_result;
    logic [NUM_SPIN*BIT_H-1:0] hbias;
    logic                      host_we, host_re;
    logic [ROW_BITS-1:0]       host_addr;
    logic [DATA_W-1:0]         host_wdata, host_rdata;
    logic                      eng_re;
    logic [ROW_BITS-1:0]       eng_addr;
    j_row_u                    eng_rdata;

    //////////////////////////////////////////////////
    // host register port
    //////////////////////////////////////////////////
    ising_regs #(
        .ADDR_W          (ADDR_W          )
    ) i_regs (
        .clk_i           (clk_i           ),
        .reset_i         (reset_i         ),
        .s_axi_awaddr_i  (s_axi_awaddr_i  ),
        .s_axi_awvalid_i (s_axi_awvalid_i ),
        .s_axi_awready_o (s_axi_awready_o ),
        .s_axi_wdata_i   (s_axi_wdata_i   ),
        .s_axi_wstrb_i   (s_axi_wstrb_i   ),
        .s_axi_wvalid_i  (s_axi_wvalid_i  ),
        .s_axi_wready_o  (s_axi_wready_o  ),
        .s_axi_bresp_o   (s_axi_bresp_o   ),
        .s_axi_bvalid_o  (s_axi_bvalid_o  ),
        .s_axi_bready_i  (s_axi_bready_i  ),
        .s_axi_araddr_i  (s_axi_araddr_i  ),
        .s_axi_arvalid_i (s_axi_arvalid_i ),
        .s_axi_arready_o (s_axi_arready_o ),
        .s_axi_rdata_o   (s_axi_rdata_o   ),
        .s_axi_rresp_o   (s_axi_rresp_o   ),
        .s_axi_rvalid_o  (s_axi_rvalid_o  ),
        .s_axi_rready_i  (s_axi_rready_i  ),
        .start_o         (start           ),
        .sweeps_o        (sweeps          ),
        .spin_init_o     (spin_init       ),
        .hbias_o         (hbias           ),
        .mem_we_o        (host_we         ),
        .mem_re_o        (host_re         ),
        .mem_addr_o      (host_addr       ),
        .mem_wdata_o     (host_wdata      ),
        .mem_rdata_i     (host_rdata      ),
        .busy_i          (busy            ),
        .done_i          (done            ),
        .spin_result_i   (spin_result     )
    );

    //////////////////////////////////////////////////
    // coupling memory, shared by host and engine
    //////////////////////////////////////////////////
    coupling_mem i_mem (
        .clk_i           (clk_i           ),
        .host_we_i       (host_we         ),
        .host_re_i       (host_re         ),
        .host_addr_i     (host_addr       ),
        .host_wdata_i    (host_wdata      ),
        .host_rdata_o    (host_rdata      ),
        .eng_re_i        (eng_re          ),
        .eng_addr_i      (eng_addr        ),
        .eng_rdata_o     (eng_rdata       )
    );

    spin_engine i_engine (
        .clk_i           (clk_i           ),
        .reset_i         (reset_i         ),
        .start_i         (start           ),
        .sweeps_i        (sweeps          ),
        .spin_init_i     (spin_init       ),
        .hbias_i         (hbias           ),
        .mem_re_o        (eng_re          ),
        .mem_addr_o      (eng_addr        ),
        .mem_rdata_i     (eng_rdata       ),
        .busy_o          (busy            ),
        .done_o          (done            ),
        .spin_result_o   (spin_result     )
    );

endmodule

// ==== bench/ising_checker.sv ====
`timescale 1ns/10ps
// bus snooper with a shadow of the registers and coupling rows
// reference model of the spin sweeps, read data and response checks

module ising_checker import ising_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic [7:0]  awaddr_i,
    input  logic        awvalid_i,
    input  logic        awready_i,
    input  logic [31:0] wdata_i,
    input  logic [3:0]  wstrb_i,
    input  logic        wvalid_i,
    input  logic        wready_i,
    input  logic [1:0]  bresp_i,
    input  logic        bvalid_i,
    input  logic        bready_i,
    input  logic [7:0]  araddr_i,
    input  logic        arvalid_i,
    input  logic        arready_i,
    input  logic [31:0] rdata_i,
    input  logic [1:0]  rresp_i,
    input  logic        rvalid_i,
    input  logic        rready_i,
    output int          errors_o
);
    logic [31:0] rows_sh [NUM_SPIN];
    logic [31:0] hbias_sh, exp_word;
    logic [7:0]  init_sh, result_sh, a_word, rd_addr;
    logic [3:0]  sweeps_sh;
    logic [1:0]  exp_resp;
    logic [1:0]  st_exp;      // done and busy as the DUT samples them
    logic        st_pending;  // STATUS read accepted on the last edge
    logic        started, busy_now, is_j, is_start;
    int          busy_left;  // cycles of engine run still ahead
    logic [7:0]  rd_q [$];

    // zero temperature sweeps, bit 1 stands for spin +1
    function automatic logic [7:0] ref_result(logic [7:0] s, logic [31:0] h, logic [3:0] n);
        int f;
        for (int k = 0; k < n; k++) begin
            for (int i = 0; i < NUM_SPIN; i++) begin
                f = $signed(h[4*i +: 4]);
                for (int j = 0; j < NUM_SPIN; j++) begin
                    if (j != i) f += (s[j] ? 1 : -1) * $signed(rows_sh[i][4*j +: 4]);
                end
                s[i] = (f >= 0);
            end
        end
        return s;
    endfunction

    function automatic logic [31:0] expected_word(logic [7:0] a);
        case (a)
            REG_STATUS:      return {30'd0, st_exp};
            REG_SWEEPS:      return {28'd0, sweeps_sh};
            REG_SPIN_INIT:   return {24'd0, init_sh};
            REG_SPIN_RESULT: return {24'd0, result_sh};
            REG_HBIAS:       return hbias_sh;
            default:         return (a >= J_BASE && a < J_BASE + J_SPAN)
                                    ? rows_sh[a[4:2]] : 32'd0;
        endcase
    endfunction

    always @(posedge clk_i) begin
        if (reset_i) begin
            {hbias_sh, init_sh, result_sh, sweeps_sh} = '0;
            started    = 1'b0;
            busy_left  = 0;
            exp_resp   = RESP_OKAY;
            st_exp     = 2'b00;
            st_pending = 1'b0;
            errors_o   = 0;
            rd_q.delete();
        end else begin
            busy_now = (busy_left > 0);
            if (busy_now) busy_left--;
            //////////////////////////////////////////////////
            // write snoop
            //////////////////////////////////////////////////
            if (awready_i !== wready_i) begin
                $display("awready and wready did not pulse together, time %0t", $time);
                errors_o++;
            end
            if (awready_i && awvalid_i && wready_i && wvalid_i) begin
                a_word   = {awaddr_i[7:2], 2'b00};
                is_j     = (a_word >= J_BASE) && (a_word < J_BASE + J_SPAN);
                is_start = (a_word == REG_CTRL) && wstrb_i[0] && wdata_i[0];
                exp_resp = (busy_now && (is_j || is_start)) ? RESP_SLVERR : RESP_OKAY;
                if (exp_resp == RESP_OKAY) begin
                    case (a_word)
                        REG_SWEEPS:    if (wstrb_i[0]) sweeps_sh = wdata_i[3:0];
                        REG_SPIN_INIT: if (wstrb_i[0]) init_sh = wdata_i[7:0];
                        REG_HBIAS: begin
                            for (int b = 0; b < 4; b++) begin
                                if (wstrb_i[b]) hbias_sh[8*b +: 8] = wdata_i[8*b +: 8];
                            end
                        end
                        REG_CTRL: begin
                            if (is_start) begin
                                result_sh = ref_result(init_sh, hbias_sh, sweeps_sh);
                                started   = 1'b1;
                                // start pulse cycle plus the run itself
                                busy_left = (sweeps_sh == 0) ? 2 : 16 * sweeps_sh + 1;
                            end
                        end
                        default: if (is_j) rows_sh[a_word[4:2]] = wdata_i;  // whole row
                    endcase
                end
            end
            if (bvalid_i && bready_i && bresp_i !== exp_resp) begin
                $display("write response was %0d where %0d was expected, time %0t",
                         bresp_i, exp_resp, $time);
                errors_o++;
            end
            //////////////////////////////////////////////////
            // read compare
            //////////////////////////////////////////////////
            // status word is taken one edge after its read handshake
            if (st_pending) begin
                st_exp     = {started && !busy_now, busy_now};
                st_pending = 1'b0;
            end
            if (arready_i && arvalid_i) begin
                rd_q.push_back({araddr_i[7:2], 2'b00});
                st_pending = ({araddr_i[7:2], 2'b00} == REG_STATUS);
            end
            if (rvalid_i && rready_i) begin
                if (rd_q.size() == 0) begin
                    $display("read data returned without a read request, time %0t", $time);
                    errors_o++;
                end else begin
                    rd_addr  = rd_q.pop_front();
                    exp_word = expected_word(rd_addr);
                    if (rresp_i !== RESP_OKAY) begin
                        $display("read response was not OKAY at 0x%02h, time %0t", rd_addr, $time);
                        errors_o++;
                    end
                    if (rdata_i !== exp_word) begin
                        $display("MISMATCH %0t: addr 0x%02h read 0x%08h expected 0x%08h",
                                 $time, rd_addr, rdata_i, exp_word);
                        errors_o++;
                    end
                end
            end
        end
    end

endmodule

// ==== bench/tb_ising.sv ====
`timescale 1ns/10ps
// testbench of the ising core
// clock, reset, LFSR, AXI4-Lite tasks, test sequence, timeout, summary

module tb_ising import ising_pkg::*; ();
    localparam int TIMEOUT_CYCLES = 40 * (16 * 15 + 60) + 4000;

    logic        clk = 1'b0;
    logic        reset;
    logic [7:0]  awaddr, araddr;
    logic [31:0] wdata, rdata, last_rdata;
    logic [3:0]  wstrb;
    logic [1:0]  bresp, rresp, last_bresp;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    logic        use_delay;  // random bready/rready stalls
    logic [31:0] lfsr_q = 32'h4b03;
    int          cycles = 0;
    int          chk_errors, tb_errors, errs_before;

    always #20 clk = ~clk;

    ising_core_top #(.ADDR_W(8)) i_dut (
        .clk_i(clk), .reset_i(reset),
        .s_axi_awaddr_i(awaddr), .s_axi_awvalid_i(awvalid), .s_axi_awready_o(awready),
        .s_axi_wdata_i(wdata), .s_axi_wstrb_i(wstrb), .s_axi_wvalid_i(wvalid),
        .s_axi_wready_o(wready), .s_axi_bresp_o(bresp), .s_axi_bvalid_o(bvalid),
        .s_axi_bready_i(bready), .s_axi_araddr_i(araddr), .s_axi_arvalid_i(arvalid),
        .s_axi_arready_o(arready), .s_axi_rdata_o(rdata), .s_axi_rresp_o(rresp),
        .s_axi_rvalid_o(rvalid), .s_axi_rready_i(rready)
    );

    ising_checker i_chk (
        .clk_i(clk), .reset_i(reset),
        .awaddr_i(awaddr), .awvalid_i(awvalid), .awready_i(awready), .wdata_i(wdata),
        .wstrb_i(wstrb), .wvalid_i(wvalid), .wready_i(wready), .bresp_i(bresp),
        .bvalid_i(bvalid), .bready_i(bready), .araddr_i(araddr), .arvalid_i(arvalid),
        .arready_i(arready), .rdata_i(rdata), .rresp_i(rresp), .rvalid_i(rvalid),
        .rready_i(rready), .errors_o(chk_errors)
    );

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout, the run was stopped after %0d cycles", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    // fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    //////////////////////////////////////////////////
    // AXI4-Lite master tasks
    //////////////////////////////////////////////////
    task automatic axi_write(input logic [7:0] a, input logic [31:0] d, input logic [3:0] s);
        awaddr  = a;
        wdata   = d;
        wstrb   = s;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        while (!(awready && wready)) next_cycle();
        next_cycle();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        repeat (use_delay ? rand_bits(2) : 0) next_cycle();
        bready = 1'b1;
        while (!bvalid) next_cycle();
        last_bresp = bresp;
        next_cycle();
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] a);
        araddr  = a;
        arvalid = 1'b1;
        while (!arready) next_cycle();
        next_cycle();
        arvalid = 1'b0;
        repeat (use_delay ? rand_bits(2) : 0) next_cycle();
        rready = 1'b1;
        while (!rvalid) next_cycle();
        last_rdata = rdata;
        next_cycle();
        rready = 1'b0;
    endtask

    task automatic load_problem();
        for (int r = 0; r < NUM_SPIN; r++) axi_write(8'(J_BASE + 4 * r), rand_bits(32), 4'hf);
        axi_write(REG_HBIAS, rand_bits(32), 4'hf);
        axi_write(REG_SPIN_INIT, rand_bits(8), 4'h1);
    endtask

    task automatic start_run(input logic [3:0] n);
        axi_write(REG_SWEEPS, {28'd0, n}, 4'h1);
        axi_write(REG_CTRL, 32'd1, 4'hf);
    endtask

    task automatic wait_result();
        do axi_read(REG_STATUS); while (last_rdata[1:0] != 2'b10);  // idle and done
        axi_read(REG_SPIN_RESULT);
    endtask

    task automatic read_config();
        for (int r = 0; r < NUM_SPIN; r++) axi_read(8'(J_BASE + 4 * r));
        axi_read(REG_SWEEPS);
        axi_read(REG_SPIN_INIT);
        axi_read(REG_HBIAS);
    endtask

    task automatic report_test(input string name);
        $display("test %-16s %0d errors", name, chk_errors + tb_errors - errs_before);
        errs_before = chk_errors + tb_errors;
    endtask

    initial begin
        {awaddr, araddr, wdata, wstrb} = '0;
        {awvalid, wvalid, bready, arvalid, rready, use_delay} = '0;
        tb_errors   = 0;
        errs_before = 0;
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #2 reset = 1'b0;

        if (bvalid || rvalid) begin
            $display("bvalid or rvalid is high right after reset");
            tb_errors++;
        end
        axi_read(REG_STATUS);
        axi_read(REG_SPIN_RESULT);
        axi_read(REG_SWEEPS);
        axi_read(REG_SPIN_INIT);
        axi_read(REG_HBIAS);
        report_test("reset_values");

        axi_write(REG_SWEEPS, rand_bits(32), rand_bits(4));
        axi_write(REG_SPIN_INIT, rand_bits(32), rand_bits(4));
        axi_write(REG_HBIAS, rand_bits(32), rand_bits(4));
        for (int r = 0; r < NUM_SPIN; r++) begin
            axi_write(8'(J_BASE + 4 * r), rand_bits(32), rand_bits(4));
        end
        read_config();
        report_test("write_read");

        load_problem();
        start_run(4'd1);
        wait_result();
        start_run(4'd0);  // result is the init vector
        wait_result();
        report_test("single_sweep");

        repeat (10) begin
            load_problem();
            start_run(4'd1 + 4'(rand_bits(4) % 15));
            wait_result();
        end
        report_test("multi_sweep");

        load_problem();
        start_run(4'd15);
        axi_write(8'(J_BASE + 12), rand_bits(32), 4'hf);
        if (last_bresp !== RESP_SLVERR) begin
            $display("row write during a run was not refused");
            tb_errors++;
        end
        axi_write(REG_CTRL, 32'd1, 4'hf);
        if (last_bresp !== RESP_SLVERR) begin
            $display("second start during a run was not refused");
            tb_errors++;
        end
        axi_read(8'(J_BASE + 12));
        wait_result();
        report_test("refuse_busy");

        use_delay = 1'b1;
        load_problem();
        start_run(4'd1 + 4'(rand_bits(4) % 15));
        wait_result();
        read_config();
        report_test("back_pressure");

        $display("total %0d checker errors, %0d testbench errors", chk_errors, tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
hdl/ising_pkg.sv
hdl/coupling_mem.sv
hdl/spin_engine.sv
hdl/ising_regs.sv
hdl/ising_core_top.sv
bench/ising_checker.sv
bench/tb_ising.sv
